/* tests/cpu_stimulus.txt */
// word 0 is the program length in words, then the program, four words to a line
// records: kind (1 writeback, 2 store), test, register or byte address, value; kind 0 ends
1b
20010005 2002000c 2003fffd 00222020  // test 1: addi r1 r2 r3, add r4
00412822 00223024 00223825 0061402a  // sub r5, and r6, or r7, slt r8
00854820 01215022 01495820           // test 2: chain r9 r10 r11
ac0b0008 8c0c0008 01816820           // test 3: sw r11, lw r12, add r13 uses r12
10220003 200e0001 200f0002 20100003  // test 4: beq not taken, r14 r15 r16 retire
10840003 20110007 20120007 20130007  // beq taken, r17 r18 r19 flushed
20140009                             // branch target writes r20
00220020 0001a820 20000037 ac00000c  // test 5: writes to r0, add r21, sw r0
1 1 01 00000005  1 1 02 0000000c
1 1 03 fffffffd  1 1 04 00000011
1 1 05 00000007  1 1 06 00000004
1 1 07 0000000d  1 1 08 00000001
1 2 09 00000018  1 2 0a 00000013
1 2 0b 0000002b  2 3 08 0000002b
1 3 0c 0000002b  1 3 0d 00000030
1 4 0e 00000001  1 4 0f 00000002
1 4 10 00000003  1 4 14 00000009
1 5 15 00000005  2 5 0c 00000000
0 0 00 00000000

/* filelist.f */
+incdir+include
source/pipelinePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/pipelineControl.sv
source/pipelineCpu.sv
tests/pipelineCpuTb.sv

/* tests/pipelineCpuTb.sv */
// testbench for the five-stage MIPS pipeline checking its writeback and store traces
`timescale 1ns/1ps
`include "pipeline_config.svh"

module pipelineCpuTb;
    logic clk;
    logic reset;
    logic imemLoad;
    logic [$clog2(`IMEM_WORDS)-1:0] imemLoadAddr;
    pipelinePkg::wordT imemLoadData;
    logic wbValid;
    pipelinePkg::regIndexT wbReg;
    pipelinePkg::wordT wbData;
    logic storeValid;
    pipelinePkg::wordT storeAddr;
    pipelinePkg::wordT storeData;

    pipelinePkg::wordT stim [256];
    // pending records held as stim indexes of their kind words
    int wbQ[$];
    int storeQ[$];
    int testErrors [16];
    int errorCount = 0;
    int checkCount = 0;

    pipelineCpu dut (
        .clk, .reset, .imemLoad, .imemLoadAddr, .imemLoadData,
        .wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkWriteback(input int test, input pipelinePkg::regIndexT expReg,
                                  input pipelinePkg::wordT expData);
        checkCount++;
        if (wbReg !== expReg || wbData !== expData) begin
            $display("Fail %0t: test %0d writeback r%0d = %h, expected r%0d = %h",
                     $time, test, wbReg, wbData, expReg, expData);
            errorCount++;
            testErrors[test]++;
        end
    endtask

    task automatic checkStore(input int test, input pipelinePkg::wordT expAddr,
                              input pipelinePkg::wordT expData);
        checkCount++;
        if (storeAddr !== expAddr || storeData !== expData) begin
            $display("Fail %0t: test %0d store [%h] = %h, expected [%h] = %h",
                     $time, test, storeAddr, storeData, expAddr, expData);
            errorCount++;
            testErrors[test]++;
        end
    endtask

    task automatic reportStray(input int test, input string trace);
        $display("test %0d: %s pulse at %0t with no record left to match it",
                 test, trace, $time);
        errorCount++;
        testErrors[test]++;
    endtask

    initial begin
        int progLen;
        int idx;
        int cycles;
        int lastTest;
        int test;
        int passed;
        int failed;

        reset = 1'b1;
        imemLoad = 1'b0;
        imemLoadAddr = '0;
        imemLoadData = '0;
        passed = 0;
        failed = 0;
        $readmemh("tests/cpu_stimulus.txt", stim);
        progLen = stim[0];
        lastTest = 0;
        // four-word records follow the program until a zero kind word
        for (idx = progLen + 1; idx + 3 < 256 && (stim[idx] == 1 || stim[idx] == 2);
             idx += 4) begin
            if (stim[idx] == 1) begin
                wbQ.push_back(idx);
            end else begin
                storeQ.push_back(idx);
            end
            lastTest = stim[idx + 1];
        end
        if (wbQ.size() == 0) begin
            $display("no expected records were read from the stimulus file");
            errorCount++;
        end

        // every imem word written under reset before four idle cycles
        for (int a = 0; a < `IMEM_WORDS + 4; a++) begin
            @(posedge clk);
            #1;
            imemLoad = (a < `IMEM_WORDS);
            imemLoadAddr = a[$clog2(`IMEM_WORDS)-1:0];
            imemLoadData = (a < progLen) ? stim[a + 1] : '0;
            if (wbValid !== 1'b0 || storeValid !== 1'b0) begin
                $display("test 0: a trace output was not low while reset was held at %0t",
                         $time);
                errorCount++;
                testErrors[0]++;
            end
        end
        @(posedge clk);
        #1;
        reset = 1'b0;

        // test 0 is the quiet reset window and owns no records
        test = 0;
        cycles = 0;
        while (test <= lastTest && cycles <= `TB_TIMEOUT_CYCLES) begin
            if ((wbQ.size() == 0 || stim[wbQ[0] + 1] != test) &&
                (storeQ.size() == 0 || stim[storeQ[0] + 1] != test)) begin
                if (testErrors[test] == 0) begin
                    $display("test %0d passed", test);
                    passed++;
                end else begin
                    $display("test %0d failed with %0d errors", test, testErrors[test]);
                    failed++;
                end
                test++;
                cycles = 0;
            end else begin
                @(negedge clk);
                cycles++;
                if (wbValid === 1'b1 && wbQ.size() == 0) begin
                    reportStray(test, "writeback");
                end else if (wbValid === 1'b1) begin
                    idx = wbQ.pop_front();
                    checkWriteback(stim[idx + 1], stim[idx + 2][4:0], stim[idx + 3]);
                end
                if (storeValid === 1'b1 && storeQ.size() == 0) begin
                    reportStray(test, "store");
                end else if (storeValid === 1'b1) begin
                    idx = storeQ.pop_front();
                    checkStore(stim[idx + 1], stim[idx + 2], stim[idx + 3]);
                end
            end
        end
        if (test <= lastTest) begin
            $display("timeout: test %0d still waiting for trace pulses after %0d cycles",
                     test, cycles);
            failed++;
        end

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checkCount, errorCount);
        if (failed == 0 && errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

/* source/pipelineCpu.sv */
// five-stage MIPS pipeline top level with writeback and store traces
`timescale 1ns/1ps
`include "pipeline_config.svh"

module pipelineCpu (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           imemLoad,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemLoadAddr,
    input  pipelinePkg::wordT              imemLoadData,
    output logic                           wbValid,
    output pipelinePkg::regIndexT          wbReg,
    output pipelinePkg::wordT              wbData,
    output logic                           storeValid,
    output pipelinePkg::wordT              storeAddr,
    output pipelinePkg::wordT              storeData
);
    pipelinePkg::wordT instrD, pcPlus4D, branchTarget, resultW;
    logic validD, stall, flush, branchTaken;
    logic regWriteD, memToRegD, memWriteD, branchD, aluSrcD, regDstD;
    pipelinePkg::aluOpT aluOpD, aluOpE;
    pipelinePkg::wordT regA, regB, signImmE, pcPlus4E;
    pipelinePkg::regIndexT rsE, rtE, rdE, writeRegM, writeRegW;
    logic regWriteE, memToRegE, memWriteE, branchE, aluSrcE, regDstE, validE;
    pipelinePkg::forwardSelT forwardA, forwardB;
    pipelinePkg::wordT aluResultM, writeDataM, branchTargetM;
    logic zeroM, regWriteM, memToRegM, memWriteM, branchM, validM, regWriteW;

    fetchStage fetch (
        .clk, .reset, .stall, .branchTaken, .branchTarget,
        .imemLoad, .imemLoadAddr, .imemLoadData,
        .instrD, .pcPlus4D, .validD
    );

    pipelineControl control (
        .clk, .reset, .instrD, .validD, .branchTaken, .memToRegE, .rtE, .rsE,
        .writeRegM, .regWriteM, .writeRegW, .regWriteW,
        .regWriteD, .memToRegD, .memWriteD, .branchD, .aluSrcD, .regDstD, .aluOpD,
        .stall, .flush, .forwardA, .forwardB
    );

    decodeStage decode (
        .clk, .reset, .stall, .flush, .instrD, .pcPlus4D, .validD,
        .regWriteD, .memToRegD, .memWriteD, .branchD, .aluSrcD, .regDstD, .aluOpD,
        .writeRegW, .regWriteW, .resultW,
        .regA, .regB, .signImmE, .pcPlus4E, .rsE, .rtE, .rdE,
        .regWriteE, .memToRegE, .memWriteE, .branchE, .aluSrcE, .regDstE, .aluOpE,
        .validE
    );

    executeStage execute (
        .clk, .reset, .flush, .regA, .regB, .signImmE, .pcPlus4E, .rtE, .rdE,
        .regWriteE, .memToRegE, .memWriteE, .branchE, .aluSrcE, .regDstE, .aluOpE,
        .validE, .forwardA, .forwardB, .resultW,
        .aluResultM, .writeDataM, .writeRegM, .branchTargetM, .zeroM,
        .regWriteM, .memToRegM, .memWriteM, .branchM, .validM
    );

    memoryStage memory (
        .clk, .reset, .aluResultM, .writeDataM, .writeRegM, .branchTargetM, .zeroM,
        .regWriteM, .memToRegM, .memWriteM, .branchM, .validM,
        .branchTaken, .branchTarget, .storeValid, .storeAddr, .storeData,
        .resultW, .writeRegW, .regWriteW, .wbValid, .wbReg, .wbData
    );
endmodule

/* source/pipelineControl.sv */
// pipeline control: instruction decode, load-use stall, forwarding and branch flush
`timescale 1ns/1ps

module pipelineControl (
    input  logic                    clk,
    input  logic                    reset,
    input  pipelinePkg::wordT       instrD,
    input  logic                    validD,
    input  logic                    branchTaken,
    input  logic                    memToRegE,
    input  pipelinePkg::regIndexT   rtE,
    input  pipelinePkg::regIndexT   rsE,
    input  pipelinePkg::regIndexT   writeRegM,
    input  logic                    regWriteM,
    input  pipelinePkg::regIndexT   writeRegW,
    input  logic                    regWriteW,
    output logic                    regWriteD,
    output logic                    memToRegD,
    output logic                    memWriteD,
    output logic                    branchD,
    output logic                    aluSrcD,
    output logic                    regDstD,
    output pipelinePkg::aluOpT      aluOpD,
    output logic                    stall,
    output logic                    flush,
    output pipelinePkg::forwardSelT forwardA,
    output pipelinePkg::forwardSelT forwardB
);
    pipelinePkg::opcodeT   opcode;
    pipelinePkg::functT    funct;
    pipelinePkg::regIndexT rsD;
    pipelinePkg::regIndexT rtD;
    logic usesRs;
    logic usesRt;
    logic usesRsE;
    logic usesRtE;

    assign opcode = pipelinePkg::opcodeT'(instrD[31:26]);
    assign funct = pipelinePkg::functT'(instrD[5:0]);
    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];

    // anything not listed decodes as a nop
    always_comb begin
        {regWriteD, memToRegD, memWriteD, branchD, aluSrcD, regDstD} = '0;
        {usesRs, usesRt} = '0;
        aluOpD = pipelinePkg::aluAdd;
        case (opcode)
            pipelinePkg::rType: begin
                {regWriteD, regDstD, usesRs, usesRt} = 4'b1111;
                case (funct)
                    pipelinePkg::addFn: aluOpD = pipelinePkg::aluAdd;
                    pipelinePkg::subFn: aluOpD = pipelinePkg::aluSub;
                    pipelinePkg::andFn: aluOpD = pipelinePkg::aluAnd;
                    pipelinePkg::orFn:  aluOpD = pipelinePkg::aluOr;
                    pipelinePkg::sltFn: aluOpD = pipelinePkg::aluSlt;
                    default: {regWriteD, regDstD, usesRs, usesRt} = 4'b0000;
                endcase
            end
            pipelinePkg::addiOp: {regWriteD, aluSrcD, usesRs} = 3'b111;
            pipelinePkg::lwOp:   {regWriteD, memToRegD, aluSrcD, usesRs} = 4'b1111;
            pipelinePkg::swOp:   {memWriteD, aluSrcD, usesRs, usesRt} = 4'b1111;
            pipelinePkg::beqOp: begin
                {branchD, usesRs, usesRt} = 3'b111;
                aluOpD = pipelinePkg::aluSub;
            end
            default: ;
        endcase
    end

    // a load result is not ready for the very next instruction
    assign stall = validD && memToRegE && rtE != '0 &&
                   ((usesRs && rsD == rtE) || (usesRt && rtD == rtE));
    assign flush = branchTaken;

    // shadow of which source fields the execute instruction really reads
    always_ff @(posedge clk) begin
        if (reset || stall || flush || !validD) begin
            usesRsE <= 1'b0;
            usesRtE <= 1'b0;
        end else begin
            usesRsE <= usesRs;
            usesRtE <= usesRt;
        end
    end

    // memory stage is younger, so it takes priority
    assign forwardA = (usesRsE && regWriteM && writeRegM != '0 && writeRegM == rsE) ?
                      pipelinePkg::fromMemoryStage :
                      (usesRsE && regWriteW && writeRegW != '0 && writeRegW == rsE) ?
                      pipelinePkg::fromWriteback : pipelinePkg::fromRegister;
    assign forwardB = (usesRtE && regWriteM && writeRegM != '0 && writeRegM == rtE) ?
                      pipelinePkg::fromMemoryStage :
                      (usesRtE && regWriteW && writeRegW != '0 && writeRegW == rtE) ?
                      pipelinePkg::fromWriteback : pipelinePkg::fromRegister;
endmodule

/* source/memoryStage.sv */
// memory stage with data memory, branch decision and memory/writeback register
`timescale 1ns/1ps
`include "pipeline_config.svh"

module memoryStage (
    input  logic                  clk,
    input  logic                  reset,
    input  pipelinePkg::wordT     aluResultM,
    input  pipelinePkg::wordT     writeDataM,
    input  pipelinePkg::regIndexT writeRegM,
    input  pipelinePkg::wordT     branchTargetM,
    input  logic                  zeroM,
    input  logic                  regWriteM,
    input  logic                  memToRegM,
    input  logic                  memWriteM,
    input  logic                  branchM,
    input  logic                  validM,
    output logic                  branchTaken,
    output pipelinePkg::wordT     branchTarget,
    output logic                  storeValid,
    output pipelinePkg::wordT     storeAddr,
    output pipelinePkg::wordT     storeData,
    output pipelinePkg::wordT     resultW,
    output pipelinePkg::regIndexT writeRegW,
    output logic                  regWriteW,
    output logic                  wbValid,
    output pipelinePkg::regIndexT wbReg,
    output pipelinePkg::wordT     wbData
);
    localparam int dmemAddrBits = $clog2(`DMEM_WORDS);

    pipelinePkg::wordT dmem [`DMEM_WORDS];
    logic [dmemAddrBits-1:0] dmemIndex;
    logic memToRegW;
    pipelinePkg::wordT aluResultW;
    pipelinePkg::wordT readDataW;

    assign dmemIndex = aluResultM[dmemAddrBits+1:2];
    assign branchTaken = validM && branchM && zeroM;
    assign branchTarget = branchTargetM;

    assign storeValid = validM && memWriteM;
    assign storeAddr = aluResultM;
    assign storeData = writeDataM;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeValid) begin
            dmem[dmemIndex] <= writeDataM;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= validM && regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        memToRegW <= memToRegM;
        aluResultW <= aluResultM;
        readDataW <= dmem[dmemIndex];
        writeRegW <= writeRegM;
    end

    assign resultW = memToRegW ? readDataW : aluResultW;

    // writes to r0 are dropped, so they leave no trace
    assign wbValid = regWriteW && writeRegW != '0;
    assign wbReg = writeRegW;
    assign wbData = resultW;
endmodule

/* source/executeStage.sv */
// execute stage with operand forwarding, ALU, branch target and execute/memory register
`timescale 1ns/1ps

module executeStage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  pipelinePkg::wordT       regA,
    input  pipelinePkg::wordT       regB,
    input  pipelinePkg::wordT       signImmE,
    input  pipelinePkg::wordT       pcPlus4E,
    input  pipelinePkg::regIndexT   rtE,
    input  pipelinePkg::regIndexT   rdE,
    input  logic                    regWriteE,
    input  logic                    memToRegE,
    input  logic                    memWriteE,
    input  logic                    branchE,
    input  logic                    aluSrcE,
    input  logic                    regDstE,
    input  pipelinePkg::aluOpT      aluOpE,
    input  logic                    validE,
    input  pipelinePkg::forwardSelT forwardA,
    input  pipelinePkg::forwardSelT forwardB,
    input  pipelinePkg::wordT       resultW,
    output pipelinePkg::wordT       aluResultM,
    output pipelinePkg::wordT       writeDataM,
    output pipelinePkg::regIndexT   writeRegM,
    output pipelinePkg::wordT       branchTargetM,
    output logic                    zeroM,
    output logic                    regWriteM,
    output logic                    memToRegM,
    output logic                    memWriteM,
    output logic                    branchM,
    output logic                    validM
);
    pipelinePkg::wordT srcA;
    pipelinePkg::wordT srcBReg;
    pipelinePkg::wordT srcB;
    pipelinePkg::wordT aluResult;

    function automatic pipelinePkg::wordT pickOperand(input pipelinePkg::forwardSelT sel,
                                                      input pipelinePkg::wordT fromReg,
                                                      input pipelinePkg::wordT fromMem,
                                                      input pipelinePkg::wordT fromWb);
        case (sel)
            pipelinePkg::fromMemoryStage: return fromMem;
            pipelinePkg::fromWriteback:   return fromWb;
            default:                      return fromReg;
        endcase
    endfunction

    assign srcA = pickOperand(forwardA, regA, aluResultM, resultW);
    assign srcBReg = pickOperand(forwardB, regB, aluResultM, resultW);
    assign srcB = aluSrcE ? signImmE : srcBReg;

    always_comb begin
        case (aluOpE)
            pipelinePkg::aluAdd: aluResult = srcA + srcB;
            pipelinePkg::aluSub: aluResult = srcA - srcB;
            pipelinePkg::aluAnd: aluResult = srcA & srcB;
            pipelinePkg::aluOr:  aluResult = srcA | srcB;
            pipelinePkg::aluSlt: aluResult = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            default:             aluResult = '0;
        endcase
    end

    // the younger instruction behind a taken branch dies here
    always_ff @(posedge clk) begin
        if (reset || flush || !validE) begin
            validM <= 1'b0;
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            memWriteM <= 1'b0;
            branchM <= 1'b0;
        end else begin
            validM <= 1'b1;
            regWriteM <= regWriteE;
            memToRegM <= memToRegE;
            memWriteM <= memWriteE;
            branchM <= branchE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResult;
        writeDataM <= srcBReg;
        writeRegM <= regDstE ? rdE : rtE;
        branchTargetM <= pcPlus4E + {signImmE[29:0], 2'b00};
        zeroM <= (aluResult == '0);
    end
endmodule

/* source/decodeStage.sv */
// decode stage with register file, sign extension and decode/execute register
`timescale 1ns/1ps

module decodeStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  pipelinePkg::wordT     instrD,
    input  pipelinePkg::wordT     pcPlus4D,
    input  logic                  validD,
    input  logic                  regWriteD,
    input  logic                  memToRegD,
    input  logic                  memWriteD,
    input  logic                  branchD,
    input  logic                  aluSrcD,
    input  logic                  regDstD,
    input  pipelinePkg::aluOpT    aluOpD,
    input  pipelinePkg::regIndexT writeRegW,
    input  logic                  regWriteW,
    input  pipelinePkg::wordT     resultW,
    output pipelinePkg::wordT     regA,
    output pipelinePkg::wordT     regB,
    output pipelinePkg::wordT     signImmE,
    output pipelinePkg::wordT     pcPlus4E,
    output pipelinePkg::regIndexT rsE,
    output pipelinePkg::regIndexT rtE,
    output pipelinePkg::regIndexT rdE,
    output logic                  regWriteE,
    output logic                  memToRegE,
    output logic                  memWriteE,
    output logic                  branchE,
    output logic                  aluSrcE,
    output logic                  regDstE,
    output pipelinePkg::aluOpT    aluOpE,
    output logic                  validE
);
    pipelinePkg::wordT     regs [32];
    pipelinePkg::regIndexT rsD;
    pipelinePkg::regIndexT rtD;
    pipelinePkg::wordT     regAD;
    pipelinePkg::wordT     regBD;
    logic                  bubble;

    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];

    // r0 reads as zero, same-cycle writeback wins over the array
    assign regAD = (rsD == '0) ? '0 :
                   (regWriteW && writeRegW == rsD) ? resultW : regs[rsD];
    assign regBD = (rtD == '0) ? '0 :
                   (regWriteW && writeRegW == rtD) ? resultW : regs[rtD];

    always_ff @(posedge clk) begin
        if (regWriteW && writeRegW != '0) begin
            regs[writeRegW] <= resultW;
        end
    end

    assign bubble = stall || flush || !validD;

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            validE <= 1'b0;
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
            memWriteE <= 1'b0;
            branchE <= 1'b0;
        end else begin
            validE <= 1'b1;
            regWriteE <= regWriteD;
            memToRegE <= memToRegD;
            memWriteE <= memWriteD;
            branchE <= branchD;
        end
    end

    always_ff @(posedge clk) begin
        regA <= regAD;
        regB <= regBD;
        signImmE <= {{16{instrD[15]}}, instrD[15:0]};
        pcPlus4E <= pcPlus4D;
        rsE <= rsD;
        rtE <= rtD;
        rdE <= instrD[15:11];
        aluSrcE <= aluSrcD;
        regDstE <= regDstD;
        aluOpE <= aluOpD;
    end
endmodule

/* source/fetchStage.sv */
// fetch stage with program counter, loadable instruction memory and fetch/decode register
`timescale 1ns/1ps
`include "pipeline_config.svh"

module fetchStage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,
    input  logic                           branchTaken,
    input  pipelinePkg::wordT              branchTarget,
    input  logic                           imemLoad,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemLoadAddr,
    input  pipelinePkg::wordT              imemLoadData,
    output pipelinePkg::wordT              instrD,
    output pipelinePkg::wordT              pcPlus4D,
    output logic                           validD
);
    localparam int imemAddrBits = $clog2(`IMEM_WORDS);

    pipelinePkg::wordT imem [`IMEM_WORDS];
    pipelinePkg::wordT pc;
    pipelinePkg::wordT pcPlus4;
    pipelinePkg::wordT instrF;

    assign pcPlus4 = pc + 32'd4;
    // word index, wraps at the memory depth
    assign instrF = imem[pc[imemAddrBits+1:2]];

    // program words only arrive while the core sits in reset
    always_ff @(posedge clk) begin
        if (reset && imemLoad) begin
            imem[imemLoadAddr] <= imemLoadData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || branchTaken) begin
            validD <= 1'b0;
        end else if (!stall) begin
            validD <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instrD <= instrF;
            pcPlus4D <= pcPlus4;
        end
    end
endmodule

/* source/pipelinePkg.sv */
// pipeline types shared by the MIPS core stages and control
package pipelinePkg;

    typedef enum logic [5:0] {
        rType  = 6'd0,
        beqOp  = 6'd4,
        addiOp = 6'd8,
        lwOp   = 6'd35,
        swOp   = 6'd43
    } opcodeT;

    typedef enum logic [5:0] {
        addFn = 6'd32,
        subFn = 6'd34,
        andFn = 6'd36,
        orFn  = 6'd37,
        sltFn = 6'd42
    } functT;

    // same encoding as the classic ALU control field
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOpT;

    typedef enum logic [1:0] {
        fromRegister    = 2'b00,
        fromWriteback   = 2'b01,
        fromMemoryStage = 2'b10
    } forwardSelT;

    typedef logic [4:0] regIndexT;
    typedef logic [31:0] wordT;

endpackage

/* include/pipeline_config.svh */
// pipeline configuration constants for the five-stage MIPS core
`ifndef PIPELINE_CONFIG_SVH
`define PIPELINE_CONFIG_SVH

// instruction memory depth in words
`define IMEM_WORDS 64

// data memory depth in words
`define DMEM_WORDS 64

// testbench only: cycles to wait for a trace pulse before giving up
`define TB_TIMEOUT_CYCLES 200

`endif
